// ==== Makefile ====
SIM      = verilator
SIMFLAGS = --binary --timing -Wno-fatal
TOP      = simonGameTb
FILELIST = simonGame.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== design/buttonInput.sv ====
`timescale 1ns/100ps
`default_nettype none

module buttonInput
    import simonDataPkg::*;
(
    input  logic    clock,
    input  logic    rstN,
    input  buttonsT buttons,
    output playT    play
);

    // Any button held this cycle
    logic    anyButton;
    // Level seen in the previous cycle
    logic    anyPrev;
    // First cycle of a press
    logic    pressEdge;
    logic    validQ;
    buttonsT buttonsQ;

    assign anyButton = |buttons;
    assign pressEdge = anyButton & ~anyPrev;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            anyPrev <= 1'b0;
            validQ  <= 1'b0;
        end else begin
            anyPrev <= anyButton;
            // One-cycle pulse per press
            validQ  <= pressEdge;
        end
    end

    // Raw vector kept as is, multi-button presses included
    always_ff @(posedge clock) begin
        if (pressEdge) begin
            buttonsQ <= buttons;
        end
    end

    assign play = '{valid: validQ, buttons: buttonsQ};

endmodule

`default_nettype wire

// ==== design/ledBuzzerOutput.sv ====
`timescale 1ns/100ps
`default_nettype none

module ledBuzzerOutput
    import simonDataPkg::*;
#(
    parameter int CLOCK_FREQ = 50_000_000
) (
    input  logic    clock,
    input  logic    rstN,
    input  buttonsT shownPlay,
    input  logic    showEnable,
    output buttonsT leds,
    output logic    buzzer
);

    // Longest half period is that of button 0
    localparam int DIV_W = $clog2(CLOCK_FREQ / 200 + 2);

    typedef logic [DIV_W-1:0] divT;

    divT divCount;
    divT halfPeriod;

    // Half period in cycles for button k, at least one
    function automatic divT toneHalf(input int k);
        int cycles;
        cycles = CLOCK_FREQ / (200 * (k + 1));
        return (cycles < 1) ? divT'(1) : divT'(cycles);
    endfunction

    // Lowest set button picks the tone
    always_comb begin
        halfPeriod = toneHalf(0);
        for (int i = NUM_BUTTONS - 1; i >= 0; i--) begin
            if (shownPlay[i]) begin
                halfPeriod = toneHalf(i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            leds <= '0;
        end else begin
            leds <= showEnable ? shownPlay : '0;
        end
    end

    // Divider held and buzzer low outside feedback
    always_ff @(posedge clock) begin
        if (!rstN || !showEnable) begin
            divCount <= '0;
            buzzer   <= 1'b0;
        end else if (divCount >= halfPeriod - 1'b1) begin
            divCount <= '0;
            buzzer   <= ~buzzer;
        end else begin
            divCount <= divCount + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/simonControl.sv ====
`timescale 1ns/100ps
`default_nettype none

module simonControl
    import simonCtrlPkg::*;
    import simonDataPkg::*;
(
    input  logic     clock,
    input  logic     rstN,
    input  logic     start,
    input  playT     play,
    input  dpStatusT status,
    output dpCtrlT   ctrl,
    output logic     won,
    output logic     lost,
    output logic     timedOut
);

    gameStateT state;
    gameStateT nextState;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state    <= idle;
            won      <= 1'b0;
            lost     <= 1'b0;
            timedOut <= 1'b0;
        end else begin
            state    <= nextState;
            // Result levels held for as long as the end state
            won      <= (nextState == simonCtrlPkg::won);
            lost     <= (nextState == simonCtrlPkg::lost);
            timedOut <= (nextState == simonCtrlPkg::timedOut);
        end
    end

    always_comb begin
        nextState = state;
        ctrl      = '0;
        case (state)
            idle, simonCtrlPkg::won, simonCtrlPkg::lost, simonCtrlPkg::timedOut: begin
                // Fresh game from round 0
                if (start) begin
                    ctrl.clearAddr       = 1'b1;
                    ctrl.clearRound      = 1'b1;
                    ctrl.restartTimeout  = 1'b1;
                    ctrl.restartFeedback = 1'b1;
                    nextState            = waitPlay;
                end
            end
            waitPlay: begin
                ctrl.runTimeout = 1'b1;
                if (status.timeoutDone) begin
                    nextState = simonCtrlPkg::timedOut;
                end else if (status.addrEqualsRound) begin
                    // Sequence repeated, next press is the new play
                    nextState = play.valid ? storeNew : waitNew;
                end else if (play.valid) begin
                    nextState = checkPlay;
                end
            end
            checkPlay: begin
                if (status.playCorrect) begin
                    ctrl.restartFeedback = 1'b1;
                    nextState            = feedback;
                end else begin
                    nextState = simonCtrlPkg::lost;
                end
            end
            nextAddr: begin
                ctrl.countAddr      = 1'b1;
                ctrl.restartTimeout = 1'b1;
                nextState           = waitPlay;
            end
            waitNew: begin
                ctrl.runTimeout = 1'b1;
                if (status.timeoutDone) begin
                    nextState = simonCtrlPkg::timedOut;
                end else if (play.valid) begin
                    nextState = storeNew;
                end
            end
            storeNew: begin
                ctrl.writeMem        = 1'b1;
                ctrl.restartFeedback = 1'b1;
                nextState            = feedback;
            end
            feedback: begin
                ctrl.runFeedback = 1'b1;
                ctrl.showPlay    = 1'b1;
                // Address equal to round only after a new play
                if (status.feedbackDone) begin
                    nextState = status.addrEqualsRound ? nextRound : nextAddr;
                end
            end
            nextRound: begin
                if (status.lastRound) begin
                    nextState = simonCtrlPkg::won;
                end else begin
                    ctrl.countRound     = 1'b1;
                    ctrl.clearAddr      = 1'b1;
                    ctrl.restartTimeout = 1'b1;
                    nextState           = waitPlay;
                end
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/simonCtrlPkg.sv ====
`default_nettype none

package simonCtrlPkg;

    // Game FSM states
    typedef enum logic [3:0] {
        idle, waitPlay, checkPlay, nextAddr, waitNew, storeNew,
        feedback, nextRound, won, lost, timedOut
    } gameStateT;

    // Commands from controller to datapath
    typedef struct packed {
        logic clearAddr;
        logic countAddr;
        logic clearRound;
        logic countRound;
        logic restartTimeout;
        logic runTimeout;
        logic restartFeedback;
        logic runFeedback;
        logic writeMem;
        logic showPlay;
    } dpCtrlT;

    // Conditions reported back by the datapath
    typedef struct packed {
        logic playCorrect;
        logic addrEqualsRound;
        logic lastRound;
        logic timeoutDone;
        logic feedbackDone;
    } dpStatusT;

endpackage

`default_nettype wire

// ==== design/simonDataPkg.sv ====
`default_nettype none

package simonDataPkg;

    // Four buttons, four LEDs, one stored play per memory word
    localparam int NUM_BUTTONS = 4;

    // Sequence memory address width
    localparam int ADDR_W = 4;

    // 16 words of sequence memory
    localparam int MEM_DEPTH = 2 ** ADDR_W;

    // Button vector, stored play and LED pattern
    typedef logic [NUM_BUTTONS-1:0] buttonsT;

    // Memory address, doubles as round number
    typedef logic [ADDR_W-1:0] addrT;

    // New play from the input side
    typedef struct packed {
        logic    valid;
        buttonsT buttons;
    } playT;

endpackage

`default_nettype wire

// ==== design/simonDatapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module simonDatapath
    import simonDataPkg::*;
    import simonCtrlPkg::*;
#(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int NUM_ROUNDS = 16,
    parameter int TIMEOUT_S  = 5
) (
    input  logic     clock,
    input  logic     rstN,
    input  playT     play,
    input  dpCtrlT   ctrl,
    output dpStatusT status,
    output buttonsT  shownPlay,
    output logic     showEnable,
    output addrT     round
);

    localparam int TIMEOUT_CYCLES  = TIMEOUT_S * CLOCK_FREQ;
    localparam int FEEDBACK_CYCLES = CLOCK_FREQ / 2;
    // Wide enough for the longer of the two timers
    localparam int TIMER_W = $clog2((TIMEOUT_CYCLES > FEEDBACK_CYCLES) ?
                                    TIMEOUT_CYCLES + 1 : FEEDBACK_CYCLES + 1);

    typedef logic [TIMER_W-1:0] timerT;

    buttonsT seqMem [MEM_DEPTH];
    buttonsT storedPlay;
    buttonsT lastPlay;
    addrT    addrCnt;
    addrT    roundCnt;
    // Bit 0 timeout, bit 1 feedback
    logic [1:0] timerRestart;
    logic [1:0] timerRun;
    logic [1:0] timerDone;

    // Sequence memory, asynchronous read at the address counter
    always_ff @(posedge clock) begin
        if (ctrl.writeMem) begin
            seqMem[addrCnt] <= play.buttons;
        end
    end

    assign storedPlay = seqMem[addrCnt];

    // Last play, cleared when a game starts
    always_ff @(posedge clock) begin
        if (!rstN || ctrl.clearRound) begin
            lastPlay <= '0;
        end else if (play.valid) begin
            lastPlay <= play.buttons;
        end
    end

    // Address and round counters
    always_ff @(posedge clock) begin
        if (!rstN || ctrl.clearAddr) begin
            addrCnt <= '0;
        end else if (ctrl.countAddr) begin
            addrCnt <= addrCnt + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN || ctrl.clearRound) begin
            roundCnt <= '0;
        end else if (ctrl.countRound) begin
            roundCnt <= roundCnt + 1'b1;
        end
    end

    assign timerRestart = {ctrl.restartFeedback, ctrl.restartTimeout};
    assign timerRun     = {ctrl.runFeedback, ctrl.runTimeout};

    // Timeout and feedback timers, done flag holds until restart
    for (genvar t = 0; t < 2; t++) begin : genTimer
        localparam int LIMIT = (t == 0) ? TIMEOUT_CYCLES : FEEDBACK_CYCLES;
        timerT count;

        always_ff @(posedge clock) begin
            if (!rstN || timerRestart[t]) begin
                count        <= '0;
                timerDone[t] <= 1'b0;
            end else if (timerRun[t] && !timerDone[t]) begin
                count <= count + 1'b1;
                // Flag rises LIMIT cycles after restart
                if (count == timerT'(LIMIT - 1)) begin
                    timerDone[t] <= 1'b1;
                end
            end
        end
    end

    assign status = '{
        playCorrect:     (lastPlay == storedPlay),
        addrEqualsRound: (addrCnt == roundCnt),
        lastRound:       (roundCnt == addrT'(NUM_ROUNDS - 1)),
        timeoutDone:     timerDone[0],
        feedbackDone:    timerDone[1]
    };

    // Feedback shows the last registered play
    assign shownPlay  = lastPlay;
    assign showEnable = ctrl.showPlay;
    assign round      = roundCnt;

endmodule

`default_nettype wire

// ==== design/simonGame.sv ====
`timescale 1ns/100ps
`default_nettype none

module simonGame
    import simonDataPkg::*;
    import simonCtrlPkg::*;
#(
    parameter int CLOCK_FREQ = 50_000_000,
    parameter int NUM_ROUNDS = 16,
    parameter int TIMEOUT_S  = 5
) (
    input  logic    clock,
    input  logic    rstN,
    input  logic    start,
    input  buttonsT buttons,
    output buttonsT leds,
    output logic    buzzer,
    output logic    won,
    output logic    lost,
    output logic    timedOut,
    output addrT    round
);

    // Press pulse and vector, to controller and datapath
    playT     play;
    dpCtrlT   ctrl;
    dpStatusT status;
    // Feedback pattern towards the output side
    buttonsT  shownPlay;
    logic     showEnable;

    buttonInput inputSide (
        .clock   ( clock   ),
        .rstN    ( rstN    ),
        .buttons ( buttons ),
        .play    ( play    )
    );

    simonControl control (
        .clock    ( clock    ),
        .rstN     ( rstN     ),
        .start    ( start    ),
        .play     ( play     ),
        .status   ( status   ),
        .ctrl     ( ctrl     ),
        .won      ( won      ),
        .lost     ( lost     ),
        .timedOut ( timedOut )
    );

    simonDatapath #(
        .CLOCK_FREQ ( CLOCK_FREQ ),
        .NUM_ROUNDS ( NUM_ROUNDS ),
        .TIMEOUT_S  ( TIMEOUT_S  )
    ) datapath (
        .clock      ( clock      ),
        .rstN       ( rstN       ),
        .play       ( play       ),
        .ctrl       ( ctrl       ),
        .status     ( status     ),
        .shownPlay  ( shownPlay  ),
        .showEnable ( showEnable ),
        .round      ( round      )
    );

    ledBuzzerOutput #(
        .CLOCK_FREQ ( CLOCK_FREQ )
    ) outputSide (
        .clock      ( clock      ),
        .rstN       ( rstN       ),
        .shownPlay  ( shownPlay  ),
        .showEnable ( showEnable ),
        .leds       ( leds       ),
        .buzzer     ( buzzer     )
    );

endmodule

`default_nettype wire

// ==== simonGame.f ====
design/simonDataPkg.sv
design/simonCtrlPkg.sv
design/buttonInput.sv
design/simonDatapath.sv
design/simonControl.sv
design/ledBuzzerOutput.sv
design/simonGame.sv
testbench/simonGameTb.sv

// ==== testbench/simonGameTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module simonGameTb
    import simonDataPkg::*;
();

    localparam int CLOCK_FREQ = 800;
    localparam int NUM_ROUNDS = 4;
    localparam int TIMEOUT_S  = 1;
    // Feedback window plus pipeline slack
    localparam int PRESS_LIMIT   = CLOCK_FREQ + 100;
    localparam int TIMEOUT_LIMIT = TIMEOUT_S * CLOCK_FREQ + 50;

    logic    clock;
    logic    rstN;
    logic    start;
    buttonsT buttons;
    buttonsT leds;
    logic    buzzer;
    logic    won;
    logic    lost;
    logic    timedOut;
    addrT    round;

    int errorCount;
    int timeoutCount;
    // Model copy of the stored sequence
    buttonsT seqModel[$];

    simonGame #(
        .CLOCK_FREQ ( CLOCK_FREQ ),
        .NUM_ROUNDS ( NUM_ROUNDS ),
        .TIMEOUT_S  ( TIMEOUT_S  )
    ) dut0 (
        .clock    ( clock    ),
        .rstN     ( rstN     ),
        .start    ( start    ),
        .buttons  ( buttons  ),
        .leds     ( leds     ),
        .buzzer   ( buzzer   ),
        .won      ( won      ),
        .lost     ( lost     ),
        .timedOut ( timedOut ),
        .round    ( round    )
    );

    // 100 ns period
    always #50 clock = ~clock;

    task automatic checkButtons(input string name, input buttonsT actual,
                                input buttonsT expected);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns %s got %b expected %b", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns %s got %b expected %b", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic checkRound(input string name, input addrT actual, input addrT expected);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns %s got %0d expected %0d", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    function automatic buttonsT randomOneHot();
        return buttonsT'(1 << ($urandom % NUM_BUTTONS));
    endfunction

    // One-cycle start pulse, then flags cleared and round back at 0
    task automatic startGame();
        @(posedge clock);
        #10;
        start = 1'b1;
        @(posedge clock);
        #10;
        start = 1'b0;
        @(negedge clock);
        checkFlag("won", won, 1'b0);
        checkFlag("lost", lost, 1'b0);
        checkFlag("timedOut", timedOut, 1'b0);
        checkRound("round", round, '0);
        seqModel.delete();
    endtask

    // Hold, release, then follow the acknowledge until leds clear again
    task automatic pressButtons(input buttonsT pressed, input logic expectShow);
        int   hold;
        int   cycles;
        int   toggles;
        logic shown;
        logic lastBuzzer;
        logic finished;
        hold       = 2 + ($urandom % 5);
        cycles     = 0;
        toggles    = 0;
        shown      = 1'b0;
        lastBuzzer = 1'b0;
        finished   = 1'b0;
        while (!finished && cycles < PRESS_LIMIT) begin
            @(posedge clock);
            #10;
            buttons = (cycles < hold) ? pressed : '0;
            @(negedge clock);
            cycles++;
            if (leds != '0) begin
                // Only a change between two shown cycles counts as a toggle
                if (shown && buzzer != lastBuzzer) begin
                    toggles++;
                end
                shown = 1'b1;
                checkButtons("leds", leds, pressed);
            end else begin
                // Tone only while the play is shown
                checkFlag("buzzer", buzzer, 1'b0);
                // Wrong play ends in lost with nothing shown
                finished = (cycles >= hold) && (expectShow ? shown : lost);
            end
            lastBuzzer = buzzer;
        end
        if (!finished) begin
            $display("Timeout: press of %b not finished within %0d cycles", pressed, PRESS_LIMIT);
            timeoutCount++;
        end
        checkFlag("leds shown", shown, expectShow);
        if (expectShow && toggles == 0) begin
            $display("Buzzer never toggled while %b was shown at %0d ns", pressed, $time);
            errorCount++;
        end
    endtask

    // Wait for any result flag, then compare all three
    task automatic waitForEnd(input logic expWon, input logic expLost,
                              input logic expTimedOut, input int limit);
        int cycles;
        cycles = 0;
        while (!(won || lost || timedOut) && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (!(won || lost || timedOut)) begin
            $display("Timeout: no game result within %0d cycles", limit);
            timeoutCount++;
        end
        checkFlag("won", won, expWon);
        checkFlag("lost", lost, expLost);
        checkFlag("timedOut", timedOut, expTimedOut);
        checkButtons("leds", leds, '0);
        checkFlag("buzzer", buzzer, 1'b0);
    endtask

    // Repeat the model sequence and add one new play per round
    task automatic playGame(input int wrongRound, input int wrongPos);
        buttonsT pick;
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            checkRound("round", round, addrT'(r));
            for (int i = 0; i < r; i++) begin
                pick = seqModel[i];
                if (r == wrongRound && i == wrongPos) begin
                    // Rotated one-hot is always another button
                    pick = {pick[NUM_BUTTONS-2:0], pick[NUM_BUTTONS-1]};
                end
                pressButtons(pick, pick == seqModel[i]);
                if (pick != seqModel[i]) begin
                    return;
                end
            end
            pick = randomOneHot();
            seqModel.push_back(pick);
            pressButtons(pick, 1'b1);
        end
    endtask

    initial begin
        int wrongRound;
        int wrongPos;
        clock        = 1'b0;
        rstN         = 1'b0;
        start        = 1'b0;
        buttons      = '0;
        errorCount   = 0;
        timeoutCount = 0;
        void'($urandom(32'h5522));
        repeat (8) @(posedge clock);
        #10;
        rstN = 1'b1;
        @(negedge clock);
        // Idle outputs before any start
        checkButtons("leds", leds, '0);
        checkFlag("buzzer", buzzer, 1'b0);
        checkFlag("won", won, 1'b0);
        checkFlag("lost", lost, 1'b0);
        checkFlag("timedOut", timedOut, 1'b0);
        checkRound("round", round, '0);

        // Full game of correct plays
        startGame();
        playGame(-1, 0);
        waitForEnd(1'b1, 1'b0, 1'b0, PRESS_LIMIT);
        checkRound("round", round, addrT'(NUM_ROUNDS - 1));

        // One wrong repeat somewhere after round 0
        startGame();
        wrongRound = 1 + ($urandom % (NUM_ROUNDS - 1));
        wrongPos   = $urandom % wrongRound;
        playGame(wrongRound, wrongPos);
        waitForEnd(1'b0, 1'b1, 1'b0, PRESS_LIMIT);

        // No presses at all
        startGame();
        waitForEnd(1'b0, 1'b0, 1'b1, TIMEOUT_LIMIT);

        // Fresh game after the timeout
        startGame();
        pressButtons(randomOneHot(), 1'b1);
        checkRound("round", round, addrT'(1));

        $display("Errors: %0d, timeouts: %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
